//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module dcache_tb -f verilog.f
	./obj_dir/Vdcache_tb > sim.log 2>&1 || echo "sim failed" >> sim.log
	cat sim.log
	! grep -q "sim failed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- verification/dcache_asserts.sv
// Bus protocol assertions on the data cache controller, bound into every controller
module dcache_asserts (
    input logic                 CLK,
    input logic                 nRST,
    input dcache_pkg::cpu_req_t cpu_req,
    input logic                 hit,
    input logic                 flushed,
    input dcache_pkg::mem_req_t mem_req,
    input logic                 mem_wait
);

    one_command: assert property (@(posedge CLK) disable iff (!nRST)
        !(mem_req.ren && mem_req.wen))
        else $error("memory read and write requested together");

    // Request frozen until the memory drops wait
    held_under_wait: assert property (@(posedge CLK) disable iff (!nRST)
        (mem_req.ren || mem_req.wen) && mem_wait |=> $stable(mem_req))
        else $error("memory request changed while wait was high");

    flushed_sticks: assert property (@(posedge CLK) disable iff (!nRST)
        flushed |=> flushed)
        else $error("flushed fell before reset");

    hit_needs_request: assert property (@(posedge CLK) disable iff (!nRST)
        hit |-> (cpu_req.ren || cpu_req.wen))
        else $error("hit without a datapath request");

endmodule

bind dcache_ctrl dcache_asserts i_asserts (.*);

//--- verification/dcache_tb.sv
// Data cache testbench: memory model with random wait and directed cache tests
module dcache_tb;
    import dcache_pkg::*;

    localparam int PERIOD        = 100;
    localparam int MEM_WORDS     = 1024;
    localparam int HIT_TIMEOUT   = 100;   // Cycles per request
    localparam int FLUSH_TIMEOUT = 1000;

    logic     CLK;
    logic     nRST;
    cpu_req_t cpu_req;
    logic     halt;
    logic     hit;
    word_t    rdata;
    logic     flushed;
    mem_req_t mem_req;
    logic     mem_wait  = 1'b0;
    word_t    mem_rdata = '0;

    word_t       mem       [MEM_WORDS];
    word_t       shadow    [MEM_WORDS];    // Value each word should read as
    logic        dirty_blk [MEM_WORDS/2];  // Blocks written since last write-back
    int          reads;
    int          writes;
    int          bus_errors;
    int          errors;
    logic [31:0] lcg_state = 32'h212f_77d7;
    int          wait_left;
    logic        busy;

    dcache_top i_dut (
        .CLK       (CLK),
        .nRST      (nRST),
        .cpu_req   (cpu_req),
        .halt      (halt),
        .hit       (hit),
        .rdata     (rdata),
        .flushed   (flushed),
        .mem_req   (mem_req),
        .mem_wait  (mem_wait),
        .mem_rdata (mem_rdata)
    );

    initial begin
        CLK = 1'b0;
        forever #(PERIOD/2) CLK = ~CLK;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic addr_t make_addr(input int tag, input int index, input int offset);
        return {tag[25:0], index[2:0], offset[0], 2'b00};
    endfunction

    task automatic show_mismatch(input string name, input word_t got, input word_t exp);
        $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
    endtask

    task automatic expect_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("[FAIL] %0t %s: got %0d, expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    // Wait of 0 to 3 cycles per transfer, set on the falling edge
    always @(negedge CLK) begin
        if (!nRST) begin
            busy      = 1'b0;
            wait_left = 0;
            mem_wait  <= 1'b0;
        end else if (mem_req.ren || mem_req.wen) begin
            if (!busy) begin
                busy      = 1'b1;
                wait_left = int'(lcg_next() >> 30);
            end
            if (wait_left > 0) begin
                wait_left = wait_left - 1;
                mem_wait  <= 1'b1;
            end else begin
                busy      = 1'b0;
                mem_wait  <= 1'b0;
                mem_rdata <= mem[mem_req.addr[11:2]];
            end
        end else begin
            mem_wait <= 1'b0;
        end
    end

    // Transfers complete on the rising edge, like the DUT sees them
    always @(posedge CLK) begin
        if (!nRST) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i]         = 32'h9e37_0000 ^ (i * 32'h0004_0021);
                shadow[i]      = 32'h9e37_0000 ^ (i * 32'h0004_0021);
                dirty_blk[i/2] = 1'b0;
            end
            reads      = 0;
            writes     = 0;
            bus_errors = 0;
        end else begin
            if (hit && cpu_req.wen) begin
                shadow[cpu_req.addr[11:2]]    = cpu_req.wdata;
                dirty_blk[cpu_req.addr[11:3]] = 1'b1;
            end
            if (mem_req.ren && !mem_wait) begin
                reads = reads + 1;
            end
            if (mem_req.wen && !mem_wait) begin
                writes = writes + 1;
                mem[mem_req.addr[11:2]] = mem_req.wdata;
                if (!dirty_blk[mem_req.addr[11:3]]) begin
                    $display("clean block written back to address %h at %0t",
                             mem_req.addr, $time);
                    bus_errors++;
                end
                if (mem_req.wdata !== shadow[mem_req.addr[11:2]]) begin
                    show_mismatch("mem_req.wdata", mem_req.wdata, shadow[mem_req.addr[11:2]]);
                    bus_errors++;
                end
                if (mem_req.addr[2]) begin
                    dirty_blk[mem_req.addr[11:3]] = 1'b0;  // Second word ends the block
                end
            end
        end
    end

    // Hold one request until hit
    task automatic access(input logic wr, input addr_t addr, input word_t wdata,
                          output word_t data);
        int   cycles;
        logic done;
        @(negedge CLK);
        cpu_req.ren   = !wr;
        cpu_req.wen   = wr;
        cpu_req.addr  = addr;
        cpu_req.wdata = wdata;
        cycles = 0;
        done   = 1'b0;
        data   = '0;
        while (!done && cycles < HIT_TIMEOUT) begin
            @(posedge CLK);
            if (hit) begin
                done = 1'b1;
                data = rdata;
            end
            cycles++;
        end
        @(negedge CLK);
        cpu_req = '0;
        if (!done) begin
            $display("no hit within %0d cycles for address %h", HIT_TIMEOUT, addr);
            errors++;
        end
    endtask

    task automatic read_check(input addr_t addr);
        word_t data;
        access(1'b0, addr, '0, data);
        if (data !== shadow[addr[11:2]]) begin
            show_mismatch("rdata", data, shadow[addr[11:2]]);
            errors++;
        end
    endtask

    task automatic write_word(input addr_t addr, input word_t wdata);
        word_t ignored;
        access(1'b1, addr, wdata, ignored);
    endtask

    task automatic read_miss_refill();
        int r0;
        r0 = reads;
        read_check(make_addr(1, 2, 0));
        expect_count("memory reads on miss", reads - r0, 2);
        r0 = reads;
        read_check(make_addr(1, 2, 1));  // Same block, now resident
        expect_count("memory reads on resident word", reads - r0, 0);
    endtask

    task automatic write_hit_stays();
        int r0;
        int w0;
        r0 = reads;
        w0 = writes;
        write_word(make_addr(1, 2, 0), 32'hdead_0001);
        read_check(make_addr(1, 2, 0));
        expect_count("memory reads after write hit", reads - r0, 0);
        expect_count("memory writes after write hit", writes - w0, 0);
    endtask

    task automatic replace_lru_line();
        int r0;
        read_check(make_addr(2, 5, 0));
        read_check(make_addr(3, 5, 0));
        read_check(make_addr(2, 5, 1));  // Tag 3 now least recent
        read_check(make_addr(4, 5, 0));
        r0 = reads;
        read_check(make_addr(4, 5, 1));
        read_check(make_addr(2, 5, 0));
        expect_count("memory reads for resident lines", reads - r0, 0);
        r0 = reads;
        read_check(make_addr(3, 5, 0));
        expect_count("memory reads for evicted line", reads - r0, 2);
    endtask

    task automatic evict_dirty_line();
        int    w0;
        addr_t a;
        write_word(make_addr(5, 6, 1), 32'hbeef_0005);
        read_check(make_addr(6, 6, 0));  // Tag 5 becomes the victim
        w0 = writes;
        read_check(make_addr(7, 6, 0));
        expect_count("write-back words for dirty line", writes - w0, 2);
        for (int off = 0; off < BLOCK_WORDS; off++) begin
            a = make_addr(5, 6, off);
            if (mem[a[11:2]] !== shadow[a[11:2]]) begin
                show_mismatch($sformatf("mem[%0d]", a[11:2]), mem[a[11:2]], shadow[a[11:2]]);
                errors++;
            end
        end
        w0 = writes;
        read_check(make_addr(8, 6, 0));  // Clean tag 6 goes
        expect_count("write-back words for clean line", writes - w0, 0);
    endtask

    task automatic halt_flush();
        int   dirty;
        int   w0;
        int   cycles;
        logic done;
        write_word(make_addr(9, 0, 1), 32'h1234_0009);
        write_word(make_addr(10, 0, 0), 32'h5678_000a);
        write_word(make_addr(7, 6, 1), 32'h0bad_0007);
        dirty = 0;
        for (int i = 0; i < MEM_WORDS/2; i++) begin
            if (dirty_blk[i]) dirty++;
        end
        w0 = writes;
        @(negedge CLK);
        halt   = 1'b1;
        cycles = 0;
        done   = 1'b0;
        while (!done && cycles < FLUSH_TIMEOUT) begin
            @(posedge CLK);
            done = flushed;
            cycles++;
        end
        if (!done) begin
            $display("flushed did not rise within %0d cycles of halt", FLUSH_TIMEOUT);
            errors++;
        end
        expect_count("write-back words in flush", writes - w0, 2 * dirty);
        for (int i = 0; i < MEM_WORDS; i++) begin
            if (mem[i] !== shadow[i]) begin
                show_mismatch($sformatf("mem[%0d]", i), mem[i], shadow[i]);
                errors++;
            end
        end
    endtask

    initial begin
        nRST    = 1'b0;
        cpu_req = '0;
        halt    = 1'b0;
        errors  = 0;
        repeat (3) @(negedge CLK);
        nRST = 1'b1;
        read_miss_refill();
        write_hit_stays();
        replace_lru_line();
        evict_dirty_line();
        halt_flush();
        $display("errors: %0d in tests, %0d on memory bus", errors, bus_errors);
        if (errors == 0 && bus_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
verilog/dcache_pkg.sv
verilog/dcache_store.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
verification/dcache_asserts.sv
verification/dcache_tb.sv

//--- verilog/dcache_ctrl.sv
// Data cache controller: hit handling, victim write-back, block refill and halt flush
module dcache_ctrl (
    input  logic                  CLK,
    input  logic                  nRST,

    // Datapath side
    input  dcache_pkg::cpu_req_t  cpu_req,
    input  logic                  halt,
    output logic                  hit,
    output dcache_pkg::word_t     rdata,
    output logic                  flushed,

    // Memory side
    output dcache_pkg::mem_req_t  mem_req,
    input  logic                  mem_wait,
    input  dcache_pkg::word_t     mem_rdata,

    // Frame store lookup
    output dcache_pkg::index_t    lookup_index,
    output dcache_pkg::tag_t      lookup_tag,
    input  logic                  lookup_hit,
    input  logic                  lookup_way,
    input  dcache_pkg::frame_t    left_frame,
    input  dcache_pkg::frame_t    right_frame,
    input  logic                  set_mru,

    // Frame store write
    output logic                  wr_en,
    output logic                  wr_way,
    output logic                  wr_mru,
    output dcache_pkg::index_t    wr_index,
    output dcache_pkg::frame_t    wr_frame
);
    import dcache_pkg::*;

    typedef enum logic [3:0] {
        IDLE,
        VICTIM_CHECK,
        WB_WORD0,
        WB_WORD1,
        REFILL_WORD0,
        REFILL_WORD1,
        FLUSH_CHECK,
        FLUSH_WB0,
        FLUSH_WB1,
        DONE
    } ctrl_state_t;

    ctrl_state_t state;
    ctrl_state_t state_next;
    logic [4:0]  flush_cnt;       // [3] picks the way, [2:0] the set
    logic [4:0]  flush_cnt_next;

    tag_t   req_tag;
    index_t req_index;
    logic   req_offset;
    logic   req_active;
    logic   flushing;
    logic   victim_way;
    frame_t hit_frame;
    frame_t victim_frame;
    frame_t scan_frame;

    // Byte address split into tag, set, word offset and byte bits
    assign req_tag    = cpu_req.addr[WORD_W-1 -: TAG_W];
    assign req_index  = cpu_req.addr[WORD_W-TAG_W-1 -: INDEX_W];
    assign req_offset = cpu_req.addr[WORD_W-TAG_W-INDEX_W-1];
    assign req_active = cpu_req.ren || cpu_req.wen;

    function automatic addr_t block_addr(tag_t tag, index_t index, logic offset);
        block_addr = {tag, index, offset, 2'b00};
    endfunction

    assign flushing = (state == FLUSH_CHECK) || (state == FLUSH_WB0) || (state == FLUSH_WB1);

    // Flush walks the store by its own counter
    assign lookup_index = flushing ? flush_cnt[2:0] : req_index;
    assign lookup_tag   = req_tag;

    assign hit_frame    = lookup_way ? right_frame : left_frame;
    assign victim_way   = ~set_mru;  // Replace the way not used last
    assign victim_frame = victim_way ? right_frame : left_frame;
    assign scan_frame   = flush_cnt[3] ? right_frame : left_frame;

    assign rdata   = hit_frame.data[req_offset];
    assign flushed = (state == DONE);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= IDLE;
            flush_cnt <= '0;
        end else begin
            state     <= state_next;
            flush_cnt <= flush_cnt_next;
        end
    end

    always_comb begin
        state_next     = state;
        flush_cnt_next = flush_cnt;
        case (state)
            IDLE: begin
                if (halt) begin
                    state_next = FLUSH_CHECK;
                end else if (req_active && !lookup_hit) begin
                    state_next = VICTIM_CHECK;
                end
            end
            VICTIM_CHECK: begin
                if (victim_frame.valid && victim_frame.dirty) begin
                    state_next = WB_WORD0;
                end else begin
                    state_next = REFILL_WORD0;
                end
            end
            WB_WORD0:     if (!mem_wait) state_next = WB_WORD1;
            WB_WORD1:     if (!mem_wait) state_next = REFILL_WORD0;
            REFILL_WORD0: if (!mem_wait) state_next = REFILL_WORD1;
            REFILL_WORD1: if (!mem_wait) state_next = IDLE;
            FLUSH_CHECK: begin
                if (flush_cnt[4]) begin
                    state_next = DONE;  // All 16 frames seen
                end else if (scan_frame.valid && scan_frame.dirty) begin
                    state_next = FLUSH_WB0;
                end else begin
                    flush_cnt_next = flush_cnt + 5'd1;
                end
            end
            FLUSH_WB0: if (!mem_wait) state_next = FLUSH_WB1;
            FLUSH_WB1: begin
                if (!mem_wait) begin
                    state_next     = FLUSH_CHECK;
                    flush_cnt_next = flush_cnt + 5'd1;
                end
            end
            DONE:    state_next = DONE;  // Held until reset
            default: state_next = IDLE;
        endcase
    end

    always_comb begin
        hit      = 1'b0;
        mem_req  = '0;
        wr_en    = 1'b0;
        wr_way   = victim_way;
        wr_mru   = set_mru;     // Refill leaves MRU alone
        wr_index = req_index;
        wr_frame = victim_frame;
        case (state)
            IDLE: begin
                if (req_active && lookup_hit) begin
                    hit      = 1'b1;
                    wr_en    = 1'b1;
                    wr_way   = lookup_way;
                    wr_mru   = lookup_way;
                    wr_frame = hit_frame;
                    if (cpu_req.wen) begin
                        wr_frame.data[req_offset] = cpu_req.wdata;
                        wr_frame.dirty            = 1'b1;
                    end
                end
            end
            WB_WORD0, WB_WORD1: begin
                mem_req.wen   = 1'b1;
                mem_req.addr  = block_addr(victim_frame.tag, req_index, state == WB_WORD1);
                mem_req.wdata = victim_frame.data[state == WB_WORD1];
            end
            REFILL_WORD0: begin
                mem_req.ren  = 1'b1;
                mem_req.addr = block_addr(req_tag, req_index, 1'b0);
                if (!mem_wait) begin
                    wr_en            = 1'b1;
                    wr_frame.valid   = 1'b0;  // Half filled, not yet usable
                    wr_frame.dirty   = 1'b0;
                    wr_frame.tag     = req_tag;
                    wr_frame.data[0] = mem_rdata;
                end
            end
            REFILL_WORD1: begin
                mem_req.ren  = 1'b1;
                mem_req.addr = block_addr(req_tag, req_index, 1'b1);
                if (!mem_wait) begin
                    wr_en            = 1'b1;
                    wr_frame.valid   = 1'b1;
                    wr_frame.dirty   = 1'b0;
                    wr_frame.tag     = req_tag;
                    wr_frame.data[1] = mem_rdata;
                end
            end
            FLUSH_WB0, FLUSH_WB1: begin
                mem_req.wen   = 1'b1;
                mem_req.addr  = block_addr(scan_frame.tag, flush_cnt[2:0], state == FLUSH_WB1);
                mem_req.wdata = scan_frame.data[state == FLUSH_WB1];
            end
            default: ;
        endcase
    end

endmodule

//--- verilog/dcache_pkg.sv
// Data cache shared definitions: address split, data types and bus request structs
package dcache_pkg;

    // Address split for a 32-bit byte address
    localparam int WORD_W      = 32;  // Data and address width
    localparam int NUM_SETS    = 8;
    localparam int INDEX_W     = 3;   // log2 of NUM_SETS
    localparam int BLOCK_WORDS = 2;   // One word-offset bit
    localparam int TAG_W       = 26;  // 32 - index - offset - byte bits

    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [WORD_W-1:0]  addr_t;  // Byte address
    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [INDEX_W-1:0] index_t;

    // One way of one set
    typedef struct packed {
        logic                         valid;
        logic                         dirty;
        tag_t                         tag;
        word_t [BLOCK_WORDS-1:0]      data;  // data[0] at the lower address
    } frame_t;

    // Request from the datapath
    typedef struct packed {
        logic  ren;
        logic  wen;
        addr_t addr;
        word_t wdata;
    } cpu_req_t;

    // Request to the memory bus, held until wait falls
    typedef struct packed {
        logic  ren;
        logic  wen;
        addr_t addr;
        word_t wdata;
    } mem_req_t;

endpackage

//--- verilog/dcache_store.sv
// Two-way frame store with per-set MRU bit, tag compare and a single write port
module dcache_store (
    input  logic                CLK,
    input  logic                nRST,

    // Lookup side
    input  dcache_pkg::index_t  lookup_index,
    input  dcache_pkg::tag_t    lookup_tag,
    output logic                lookup_hit,
    output logic                lookup_way,
    output dcache_pkg::frame_t  left_frame,
    output dcache_pkg::frame_t  right_frame,
    output logic                set_mru,

    // Write side
    input  logic                wr_en,
    input  logic                wr_way,
    input  logic                wr_mru,
    input  dcache_pkg::index_t  wr_index,
    input  dcache_pkg::frame_t  wr_frame
);
    import dcache_pkg::*;

    frame_t                left_q  [NUM_SETS];  // Way 0
    frame_t                right_q [NUM_SETS];  // Way 1
    logic   [NUM_SETS-1:0] mru_q;               // 0 means left used last

    logic left_match;
    logic right_match;

    // Frames and MRU bit of the looked-up set
    always_comb begin
        left_frame  = left_q[lookup_index];
        right_frame = right_q[lookup_index];
        set_mru     = mru_q[lookup_index];
    end

    // Only valid frames can match
    assign left_match  = left_frame.valid  && (left_frame.tag  == lookup_tag);
    assign right_match = right_frame.valid && (right_frame.tag == lookup_tag);

    always_comb begin
        lookup_hit = left_match || right_match;
        if (left_match) begin
            lookup_way = 1'b0;  // Left wins if both match
        end else begin
            lookup_way = right_match;
        end
    end

    // One frame per cycle, MRU of that set follows
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < NUM_SETS; i++) begin
                left_q[i]  <= '0;
                right_q[i] <= '0;
            end
            mru_q <= '0;
        end else if (wr_en) begin
            if (wr_way) begin
                right_q[wr_index] <= wr_frame;
            end else begin
                left_q[wr_index] <= wr_frame;
            end
            mru_q[wr_index] <= wr_mru;
        end
    end

endmodule

//--- verilog/dcache_top.sv
// Data cache top level joining the frame store and the controller
module dcache_top (
    input  logic                  CLK,
    input  logic                  nRST,

    // Datapath side
    input  dcache_pkg::cpu_req_t  cpu_req,
    input  logic                  halt,
    output logic                  hit,
    output dcache_pkg::word_t     rdata,
    output logic                  flushed,

    // Memory side
    output dcache_pkg::mem_req_t  mem_req,
    input  logic                  mem_wait,
    input  dcache_pkg::word_t     mem_rdata
);
    import dcache_pkg::*;

    // Lookup path
    index_t lookup_index;
    tag_t   lookup_tag;
    logic   lookup_hit;
    logic   lookup_way;
    frame_t left_frame;
    frame_t right_frame;
    logic   set_mru;

    // Write path
    logic   wr_en;
    logic   wr_way;
    logic   wr_mru;
    index_t wr_index;
    frame_t wr_frame;

    dcache_store i_store (
        .CLK          (CLK),
        .nRST         (nRST),
        .lookup_index (lookup_index),
        .lookup_tag   (lookup_tag),
        .lookup_hit   (lookup_hit),
        .lookup_way   (lookup_way),
        .left_frame   (left_frame),
        .right_frame  (right_frame),
        .set_mru      (set_mru),
        .wr_en        (wr_en),
        .wr_way       (wr_way),
        .wr_mru       (wr_mru),
        .wr_index     (wr_index),
        .wr_frame     (wr_frame)
    );

    dcache_ctrl i_ctrl (
        .CLK          (CLK),
        .nRST         (nRST),
        .cpu_req      (cpu_req),
        .halt         (halt),
        .hit          (hit),
        .rdata        (rdata),
        .flushed      (flushed),
        .mem_req      (mem_req),
        .mem_wait     (mem_wait),
        .mem_rdata    (mem_rdata),
        .lookup_index (lookup_index),
        .lookup_tag   (lookup_tag),
        .lookup_hit   (lookup_hit),
        .lookup_way   (lookup_way),
        .left_frame   (left_frame),
        .right_frame  (right_frame),
        .set_mru      (set_mru),
        .wr_en        (wr_en),
        .wr_way       (wr_way),
        .wr_mru       (wr_mru),
        .wr_index     (wr_index),
        .wr_frame     (wr_frame)
    );

endmodule
